/* id_stage.f */
+incdir+source
+incdir+testbench
source/id_pkg.sv
source/id_inst_decoder.sv
source/id_operand_sel.sv
source/id_jalr_redirect.sv
source/id_exe_reg.sv
source/id_stage_top.sv
testbench/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator
verilator --binary --timing -f id_stage.f --top-module tb_id_stage -o tb_id_stage \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_id_stage > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "test failed"; exit 1; } || { echo "test passed"; exit 0; }

/* source/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath widths
`define ID_XLEN        64
`define ID_INST_W      32
`define ID_REG_ADDR_W  5
`define ID_IMM12_W     12
`define ID_UIMM_W      20

// major opcodes, instruction bits 6 to 2
`define ID_OPC_LUI     5'b01101
`define ID_OPC_AUIPC   5'b00101
`define ID_OPC_JAL     5'b11011
`define ID_OPC_JALR    5'b11001
`define ID_OPC_BRANCH  5'b11000
`define ID_OPC_LOAD    5'b00000
`define ID_OPC_STORE   5'b01000
`define ID_OPC_REGIMM  5'b00100
`define ID_OPC_REGREG  5'b01100

`endif

/* source/id_exe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_exe_reg (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                stall_i,
  input  logic                valid_i,
  input  id_pkg::inst_class_e class_i,
  input  id_pkg::alu_op_e     alu_op_i,
  input  id_pkg::funct3_t     funct3_i,
  input  id_pkg::xlen_t       op1_i,
  input  id_pkg::xlen_t       op2_i,
  input  logic                rd_w_ena_i,
  input  id_pkg::reg_addr_t   rd_w_addr_i,
  input  id_pkg::imm12_t      mem_offset_i,
  input  id_pkg::pc_t         pc_i,
  input  logic                redirect_i,
  input  id_pkg::pc_t         redirect_pc_i,
  output logic                valid_o,
  output id_pkg::inst_class_e class_o,
  output id_pkg::alu_op_e     alu_op_o,
  output id_pkg::funct3_t     funct3_o,
  output id_pkg::xlen_t       op1_o,
  output id_pkg::xlen_t       op2_o,
  output logic                rd_w_ena_o,
  output id_pkg::reg_addr_t   rd_w_addr_o,
  output id_pkg::imm12_t      mem_offset_o,
  output id_pkg::pc_t         pc_o,
  output logic                redirect_o,
  output id_pkg::pc_t         redirect_pc_o
);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o       <= 1'b0;
      class_o       <= id_pkg::CLS_NONE;
      alu_op_o      <= id_pkg::ALU_NONE;
      funct3_o      <= '0;
      op1_o         <= '0;
      op2_o         <= '0;
      rd_w_ena_o    <= 1'b0;
      rd_w_addr_o   <= '0;
      mem_offset_o  <= '0;
      pc_o          <= '0;
      redirect_o    <= 1'b0;
      redirect_pc_o <= '0;
    end else if (!stall_i) begin
      // held while execute is stalled
      valid_o       <= valid_i;
      class_o       <= class_i;
      alu_op_o      <= alu_op_i;
      funct3_o      <= funct3_i;
      op1_o         <= op1_i;
      op2_o         <= op2_i;
      rd_w_ena_o    <= rd_w_ena_i;
      rd_w_addr_o   <= rd_w_addr_i;
      mem_offset_o  <= mem_offset_i;
      pc_o          <= pc_i;
      redirect_o    <= redirect_i;
      redirect_pc_o <= redirect_pc_i;
    end
  end

endmodule

`default_nettype wire

/* source/id_inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_inst_decoder (
  input  logic                inst_valid_i,
  input  id_pkg::inst_t       inst_i,
  output id_pkg::inst_class_e class_o,
  output id_pkg::alu_op_e     alu_op_o,
  output id_pkg::funct3_t     funct3_o,
  output logic                rs1_rd_o,
  output logic                rs2_rd_o,
  output id_pkg::reg_addr_t   rs1_addr_o,
  output id_pkg::reg_addr_t   rs2_addr_o,
  output logic                rd_w_ena_o,
  output id_pkg::reg_addr_t   rd_w_addr_o,
  output id_pkg::xlen_t       i_imm_o,
  output id_pkg::xlen_t       u_imm_o,
  output id_pkg::imm12_t      mem_offset_o
);

  logic [4:0]            opc;
  id_pkg::reg_addr_t     rd;
  id_pkg::reg_addr_t     rs1;
  id_pkg::reg_addr_t     rs2;
  id_pkg::funct3_t       funct3;
  logic [6:0]            funct7;
  id_pkg::imm12_t        i_imm;
  id_pkg::imm12_t        s_imm;
  logic [`ID_UIMM_W-1:0] u_field;
  logic                  sub_sel;

  assign opc     = inst_i[6:2];
  assign rd      = inst_i[11:7];
  assign funct3  = inst_i[14:12];
  assign rs1     = inst_i[19:15];
  assign rs2     = inst_i[24:20];
  assign funct7  = inst_i[31:25];
  assign i_imm   = inst_i[31:20];
  assign s_imm   = {inst_i[31:25], inst_i[11:7]};
  assign u_field = inst_i[31:12];

  // only 32-bit encodings, low bits 11
  always_comb begin
    class_o = id_pkg::CLS_NONE;
    if (inst_valid_i && (inst_i[1:0] == 2'b11)) begin
      case (opc)
        `ID_OPC_LUI:    class_o = id_pkg::CLS_LUI;
        `ID_OPC_AUIPC:  class_o = id_pkg::CLS_AUIPC;
        `ID_OPC_JAL:    class_o = id_pkg::CLS_JAL;
        `ID_OPC_JALR:   class_o = id_pkg::CLS_JALR;
        `ID_OPC_BRANCH: class_o = id_pkg::CLS_BRANCH;
        `ID_OPC_LOAD:   class_o = id_pkg::CLS_LOAD;
        `ID_OPC_STORE:  class_o = id_pkg::CLS_STORE;
        `ID_OPC_REGIMM: class_o = id_pkg::CLS_REGIMM;
        `ID_OPC_REGREG: class_o = id_pkg::CLS_REGREG;
        default:        class_o = id_pkg::CLS_NONE;
      endcase
    end
  end

  // addi has no sub form
  assign sub_sel = (class_o == id_pkg::CLS_REGREG) && funct7[5];

  // funct7[5] is instruction bit 30, the shift-arith select for both formats
  always_comb begin
    alu_op_o = id_pkg::ALU_NONE;
    case (class_o)
      id_pkg::CLS_REGREG, id_pkg::CLS_REGIMM: begin
        case (funct3)
          3'b000:  alu_op_o = sub_sel ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
          3'b001:  alu_op_o = id_pkg::ALU_SLL;
          3'b010:  alu_op_o = id_pkg::ALU_SLT;
          3'b011:  alu_op_o = id_pkg::ALU_SLTU;
          3'b100:  alu_op_o = id_pkg::ALU_XOR;
          3'b101:  alu_op_o = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
          3'b110:  alu_op_o = id_pkg::ALU_OR;
          default: alu_op_o = id_pkg::ALU_AND;
        endcase
      end
      id_pkg::CLS_LOAD, id_pkg::CLS_STORE, id_pkg::CLS_AUIPC,
      id_pkg::CLS_JAL, id_pkg::CLS_JALR: alu_op_o = id_pkg::ALU_ADD;
      default: alu_op_o = id_pkg::ALU_NONE;
    endcase
  end

  assign funct3_o = funct3;

  assign rs1_rd_o = (class_o == id_pkg::CLS_JALR)   || (class_o == id_pkg::CLS_BRANCH) ||
                    (class_o == id_pkg::CLS_LOAD)   || (class_o == id_pkg::CLS_STORE)  ||
                    (class_o == id_pkg::CLS_REGIMM) || (class_o == id_pkg::CLS_REGREG);
  assign rs2_rd_o = (class_o == id_pkg::CLS_BRANCH) || (class_o == id_pkg::CLS_STORE) ||
                    (class_o == id_pkg::CLS_REGREG);

  assign rs1_addr_o = rs1_rd_o ? rs1 : '0;
  assign rs2_addr_o = rs2_rd_o ? rs2 : '0;

  assign rd_w_ena_o = (rd != '0) &&
                      ((class_o == id_pkg::CLS_REGREG) || (class_o == id_pkg::CLS_REGIMM) ||
                       (class_o == id_pkg::CLS_LOAD)   || (class_o == id_pkg::CLS_LUI)    ||
                       (class_o == id_pkg::CLS_AUIPC)  || (class_o == id_pkg::CLS_JAL)    ||
                       (class_o == id_pkg::CLS_JALR));
  assign rd_w_addr_o = rd_w_ena_o ? rd : '0;

  assign i_imm_o = {{(`ID_XLEN-`ID_IMM12_W){i_imm[`ID_IMM12_W-1]}}, i_imm};
  // upper field left unshifted, execute does the shift
  assign u_imm_o = {{(`ID_XLEN-`ID_UIMM_W){u_field[`ID_UIMM_W-1]}}, u_field};

  assign mem_offset_o = (class_o == id_pkg::CLS_LOAD)  ? i_imm :
                        (class_o == id_pkg::CLS_STORE) ? s_imm : '0;

endmodule

`default_nettype wire

/* source/id_jalr_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_jalr_redirect (
  input  id_pkg::inst_class_e class_i,
  input  id_pkg::reg_addr_t   rs1_addr_i,
  input  id_pkg::xlen_t       op1_i,
  input  id_pkg::xlen_t       i_imm_i,
  input  logic                ex_rd_ena_i,
  input  id_pkg::reg_addr_t   ex_rd_addr_i,
  input  logic                mem_rd_ena_i,
  input  id_pkg::reg_addr_t   mem_rd_addr_i,
  input  logic                wb_rd_ena_i,
  input  id_pkg::reg_addr_t   wb_rd_addr_i,
  output logic                redirect_o,
  output id_pkg::pc_t         redirect_pc_o
);

  logic          is_jalr;
  logic          base_busy;
  id_pkg::xlen_t target;

  assign is_jalr = (class_i == id_pkg::CLS_JALR);

  // base register still being produced further down the pipe
  assign base_busy = (ex_rd_ena_i  && (ex_rd_addr_i  == rs1_addr_i)) ||
                     (mem_rd_ena_i && (mem_rd_addr_i == rs1_addr_i)) ||
                     (wb_rd_ena_i  && (wb_rd_addr_i  == rs1_addr_i));

  assign target        = op1_i + i_imm_i;
  assign redirect_o    = is_jalr && base_busy;
  assign redirect_pc_o = is_jalr ? {target[`ID_XLEN-1:1], 1'b0} : '0;

endmodule

`default_nettype wire

/* source/id_operand_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module id_operand_sel (
  input  id_pkg::inst_class_e class_i,
  input  logic                rs1_rd_i,
  input  logic                rs2_rd_i,
  input  id_pkg::reg_addr_t   rs1_addr_i,
  input  id_pkg::reg_addr_t   rs2_addr_i,
  input  id_pkg::xlen_t       rs1_data_i,
  input  id_pkg::xlen_t       rs2_data_i,
  input  logic                ex_rd_ena_i,
  input  id_pkg::reg_addr_t   ex_rd_addr_i,
  input  id_pkg::xlen_t       ex_rd_data_i,
  input  logic                mem_rd_ena_i,
  input  id_pkg::reg_addr_t   mem_rd_addr_i,
  input  id_pkg::xlen_t       mem_rd_data_i,
  input  id_pkg::pc_t         pc_i,
  input  id_pkg::xlen_t       i_imm_i,
  input  id_pkg::xlen_t       u_imm_i,
  output id_pkg::xlen_t       op1_o,
  output id_pkg::xlen_t       op2_o
);

  // execute result is newer than memory, so it wins
  function automatic id_pkg::xlen_t fwd_sel(input id_pkg::reg_addr_t addr,
                                            input id_pkg::xlen_t     rf_data);
    id_pkg::xlen_t res;
    if (ex_rd_ena_i && (ex_rd_addr_i == addr)) begin
      res = ex_rd_data_i;
    end else if (mem_rd_ena_i && (mem_rd_addr_i == addr)) begin
      res = mem_rd_data_i;
    end else begin
      res = rf_data;
    end
    return res;
  endfunction

  always_comb begin
    if (rs1_rd_i) begin
      op1_o = fwd_sel(rs1_addr_i, rs1_data_i);
    end else if ((class_i == id_pkg::CLS_AUIPC) || (class_i == id_pkg::CLS_JAL)) begin
      op1_o = pc_i;
    end else begin
      op1_o = '0;
    end
  end

  always_comb begin
    if (rs2_rd_i) begin
      op2_o = fwd_sel(rs2_addr_i, rs2_data_i);
    end else if (class_i == id_pkg::CLS_REGIMM) begin
      op2_o = i_imm_i;
    end else if ((class_i == id_pkg::CLS_LUI) || (class_i == id_pkg::CLS_AUIPC)) begin
      op2_o = u_imm_i;
    end else if ((class_i == id_pkg::CLS_JAL) || (class_i == id_pkg::CLS_JALR)) begin
      // link address is formed in execute from pc
      op2_o = pc_i;
    end else begin
      op2_o = '0;
    end
  end

endmodule

`default_nettype wire

/* source/id_pkg.sv */
`default_nettype none

`include "id_defines.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]       xlen_t;
  typedef logic [`ID_XLEN-1:0]       pc_t;
  typedef logic [`ID_INST_W-1:0]     inst_t;
  typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

  // memory size for load/store, compare kind for branch
  typedef logic [2:0]                funct3_t;

  typedef logic [`ID_IMM12_W-1:0]    imm12_t;

  typedef enum logic [3:0] {
    CLS_NONE   = 4'd0,
    CLS_LUI    = 4'd1,
    CLS_AUIPC  = 4'd2,
    CLS_JAL    = 4'd3,
    CLS_JALR   = 4'd4,
    CLS_BRANCH = 4'd5,
    CLS_LOAD   = 4'd6,
    CLS_STORE  = 4'd7,
    CLS_REGIMM = 4'd8,
    CLS_REGREG = 4'd9
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_SLL  = 4'd3,
    ALU_SLT  = 4'd4,
    ALU_SLTU = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_AND  = 4'd10
  } alu_op_e;

endpackage

`default_nettype wire

/* source/id_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_top (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                inst_valid_i,
  input  id_pkg::inst_t       inst_i,
  input  id_pkg::pc_t         pc_i,
  input  id_pkg::xlen_t       rs1_data_i,
  input  id_pkg::xlen_t       rs2_data_i,
  output id_pkg::reg_addr_t   rs1_addr_o,
  output id_pkg::reg_addr_t   rs2_addr_o,
  input  logic                ex_rd_ena_i,
  input  id_pkg::reg_addr_t   ex_rd_addr_i,
  input  id_pkg::xlen_t       ex_rd_data_i,
  input  logic                mem_rd_ena_i,
  input  id_pkg::reg_addr_t   mem_rd_addr_i,
  input  id_pkg::xlen_t       mem_rd_data_i,
  input  logic                wb_rd_ena_i,
  input  id_pkg::reg_addr_t   wb_rd_addr_i,
  input  logic                stall_i,
  output logic                valid_o,
  output id_pkg::inst_class_e class_o,
  output id_pkg::alu_op_e     alu_op_o,
  output id_pkg::funct3_t     funct3_o,
  output id_pkg::xlen_t       op1_o,
  output id_pkg::xlen_t       op2_o,
  output logic                rd_w_ena_o,
  output id_pkg::reg_addr_t   rd_w_addr_o,
  output id_pkg::imm12_t      mem_offset_o,
  output id_pkg::pc_t         pc_o,
  output logic                redirect_o,
  output id_pkg::pc_t         redirect_pc_o
);

  id_pkg::inst_class_e dec_class;
  id_pkg::alu_op_e     dec_alu_op;
  id_pkg::funct3_t     dec_funct3;
  logic                dec_rs1_rd;
  logic                dec_rs2_rd;
  logic                dec_rd_w_ena;
  id_pkg::reg_addr_t   dec_rd_w_addr;
  id_pkg::xlen_t       dec_i_imm;
  id_pkg::xlen_t       dec_u_imm;
  id_pkg::imm12_t      dec_mem_offset;
  id_pkg::xlen_t       sel_op1;
  id_pkg::xlen_t       sel_op2;
  logic                jr_redirect;
  id_pkg::pc_t         jr_redirect_pc;

  id_inst_decoder u_dec (
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .class_o      (dec_class),
    .alu_op_o     (dec_alu_op),
    .funct3_o     (dec_funct3),
    .rs1_rd_o     (dec_rs1_rd),
    .rs2_rd_o     (dec_rs2_rd),
    .rs1_addr_o   (rs1_addr_o),
    .rs2_addr_o   (rs2_addr_o),
    .rd_w_ena_o   (dec_rd_w_ena),
    .rd_w_addr_o  (dec_rd_w_addr),
    .i_imm_o      (dec_i_imm),
    .u_imm_o      (dec_u_imm),
    .mem_offset_o (dec_mem_offset)
  );

  id_operand_sel u_opsel (
    .class_i       (dec_class),
    .rs1_rd_i      (dec_rs1_rd),
    .rs2_rd_i      (dec_rs2_rd),
    .rs1_addr_i    (rs1_addr_o),
    .rs2_addr_i    (rs2_addr_o),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_rd_ena_i   (ex_rd_ena_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_ena_i  (mem_rd_ena_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .pc_i          (pc_i),
    .i_imm_i       (dec_i_imm),
    .u_imm_i       (dec_u_imm),
    .op1_o         (sel_op1),
    .op2_o         (sel_op2)
  );

  id_jalr_redirect u_jalr (
    .class_i       (dec_class),
    .rs1_addr_i    (rs1_addr_o),
    .op1_i         (sel_op1),
    .i_imm_i       (dec_i_imm),
    .ex_rd_ena_i   (ex_rd_ena_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .mem_rd_ena_i  (mem_rd_ena_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .wb_rd_ena_i   (wb_rd_ena_i),
    .wb_rd_addr_i  (wb_rd_addr_i),
    .redirect_o    (jr_redirect),
    .redirect_pc_o (jr_redirect_pc)
  );

  id_exe_reg u_exe_reg (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .stall_i       (stall_i),
    .valid_i       (inst_valid_i),
    .class_i       (dec_class),
    .alu_op_i      (dec_alu_op),
    .funct3_i      (dec_funct3),
    .op1_i         (sel_op1),
    .op2_i         (sel_op2),
    .rd_w_ena_i    (dec_rd_w_ena),
    .rd_w_addr_i   (dec_rd_w_addr),
    .mem_offset_i  (dec_mem_offset),
    .pc_i          (pc_i),
    .redirect_i    (jr_redirect),
    .redirect_pc_i (jr_redirect_pc),
    .valid_o       (valid_o),
    .class_o       (class_o),
    .alu_op_o      (alu_op_o),
    .funct3_o      (funct3_o),
    .op1_o         (op1_o),
    .op2_o         (op2_o),
    .rd_w_ena_o    (rd_w_ena_o),
    .rd_w_addr_o   (rd_w_addr_o),
    .mem_offset_o  (mem_offset_o),
    .pc_o          (pc_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_id_ref.svh */
`ifndef TB_ID_REF_SVH
`define TB_ID_REF_SVH

typedef struct packed {
  logic                valid;
  id_pkg::inst_class_e cls;
  id_pkg::alu_op_e     alu;
  id_pkg::funct3_t     funct3;
  id_pkg::xlen_t       op1;
  id_pkg::xlen_t       op2;
  logic                rd_w_ena;
  id_pkg::reg_addr_t   rd_w_addr;
  id_pkg::reg_addr_t   rs1_addr;
  id_pkg::reg_addr_t   rs2_addr;
  id_pkg::imm12_t      mem_offset;
  id_pkg::pc_t         pc;
  logic                redirect;
  id_pkg::pc_t         redirect_pc;
} exp_t;

logic [31:0] lfsr_state;

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int k = 0; k < n; k++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r = {r[30:0], fb};
  end
  return r;
endfunction

// register file model contents
function automatic id_pkg::xlen_t rf_value(input id_pkg::reg_addr_t a);
  return {16'hfeed, 11'h0, a, 16'hbeef, 11'h0, a};
endfunction

function automatic id_pkg::xlen_t fwd_value(input id_pkg::reg_addr_t a);
  if (ex_rd_ena && (ex_rd_addr == a)) return ex_rd_data;
  if (mem_rd_ena && (mem_rd_addr == a)) return mem_rd_data;
  return rf_value(a);
endfunction

function automatic exp_t ref_decode(input logic v, input id_pkg::inst_t i,
                                    input id_pkg::pc_t pc_v);
  exp_t          e;
  id_pkg::xlen_t imm_i;
  logic          rd1;
  logic          rd2;
  e = '0;
  imm_i = {{52{i[31]}}, i[31:20]};
  e.valid = v;
  e.pc = pc_v;
  e.funct3 = i[14:12];
  if (v) begin
    case (i[6:0])
      7'h37:   e.cls = id_pkg::CLS_LUI;
      7'h17:   e.cls = id_pkg::CLS_AUIPC;
      7'h6f:   e.cls = id_pkg::CLS_JAL;
      7'h67:   e.cls = id_pkg::CLS_JALR;
      7'h63:   e.cls = id_pkg::CLS_BRANCH;
      7'h03:   e.cls = id_pkg::CLS_LOAD;
      7'h23:   e.cls = id_pkg::CLS_STORE;
      7'h13:   e.cls = id_pkg::CLS_REGIMM;
      7'h33:   e.cls = id_pkg::CLS_REGREG;
      default: e.cls = id_pkg::CLS_NONE;
    endcase
  end
  rd1 = e.cls inside {id_pkg::CLS_JALR, id_pkg::CLS_BRANCH, id_pkg::CLS_LOAD,
                      id_pkg::CLS_STORE, id_pkg::CLS_REGIMM, id_pkg::CLS_REGREG};
  rd2 = e.cls inside {id_pkg::CLS_BRANCH, id_pkg::CLS_STORE, id_pkg::CLS_REGREG};
  e.rs1_addr = rd1 ? i[19:15] : 5'd0;
  e.rs2_addr = rd2 ? i[24:20] : 5'd0;
  if (rd1) e.op1 = fwd_value(e.rs1_addr);
  else if (e.cls inside {id_pkg::CLS_AUIPC, id_pkg::CLS_JAL}) e.op1 = pc_v;
  if (rd2) e.op2 = fwd_value(e.rs2_addr);
  else if (e.cls == id_pkg::CLS_REGIMM) e.op2 = imm_i;
  else if (e.cls inside {id_pkg::CLS_LUI, id_pkg::CLS_AUIPC}) e.op2 = {{44{i[31]}}, i[31:12]};
  else if (e.cls inside {id_pkg::CLS_JAL, id_pkg::CLS_JALR}) e.op2 = pc_v;
  if (e.cls inside {id_pkg::CLS_REGREG, id_pkg::CLS_REGIMM}) begin
    case (i[14:12])
      3'd0: e.alu = ((e.cls == id_pkg::CLS_REGREG) && i[30]) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'd1: e.alu = id_pkg::ALU_SLL;
      3'd2: e.alu = id_pkg::ALU_SLT;
      3'd3: e.alu = id_pkg::ALU_SLTU;
      3'd4: e.alu = id_pkg::ALU_XOR;
      3'd5: e.alu = i[30] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'd6: e.alu = id_pkg::ALU_OR;
      default: e.alu = id_pkg::ALU_AND;
    endcase
  end else if (e.cls inside {id_pkg::CLS_LOAD, id_pkg::CLS_STORE, id_pkg::CLS_AUIPC,
                             id_pkg::CLS_JAL, id_pkg::CLS_JALR}) begin
    e.alu = id_pkg::ALU_ADD;
  end
  e.rd_w_ena = (i[11:7] != 5'd0) &&
               (e.cls inside {id_pkg::CLS_REGREG, id_pkg::CLS_REGIMM, id_pkg::CLS_LOAD,
                              id_pkg::CLS_LUI, id_pkg::CLS_AUIPC, id_pkg::CLS_JAL,
                              id_pkg::CLS_JALR});
  e.rd_w_addr = e.rd_w_ena ? i[11:7] : 5'd0;
  if (e.cls == id_pkg::CLS_LOAD) e.mem_offset = i[31:20];
  else if (e.cls == id_pkg::CLS_STORE) e.mem_offset = {i[31:25], i[11:7]};
  if (e.cls == id_pkg::CLS_JALR) begin
    e.redirect = (ex_rd_ena && (ex_rd_addr == e.rs1_addr)) ||
                 (mem_rd_ena && (mem_rd_addr == e.rs1_addr)) ||
                 (wb_rd_ena && (wb_rd_addr == e.rs1_addr));
    e.redirect_pc = (e.op1 + imm_i) & ~64'd1;
  end
  return e;
endfunction

`endif

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  logic                clk;
  logic                arst_n;
  logic                inst_valid;
  id_pkg::inst_t       inst;
  id_pkg::pc_t         pc;
  id_pkg::xlen_t       rs1_data;
  id_pkg::xlen_t       rs2_data;
  id_pkg::reg_addr_t   rs1_addr;
  id_pkg::reg_addr_t   rs2_addr;
  logic                ex_rd_ena;
  id_pkg::reg_addr_t   ex_rd_addr;
  id_pkg::xlen_t       ex_rd_data;
  logic                mem_rd_ena;
  id_pkg::reg_addr_t   mem_rd_addr;
  id_pkg::xlen_t       mem_rd_data;
  logic                wb_rd_ena;
  id_pkg::reg_addr_t   wb_rd_addr;
  logic                stall;
  logic                valid;
  id_pkg::inst_class_e cls;
  id_pkg::alu_op_e     alu_op;
  id_pkg::funct3_t     funct3;
  id_pkg::xlen_t       op1;
  id_pkg::xlen_t       op2;
  logic                rd_w_ena;
  id_pkg::reg_addr_t   rd_w_addr;
  id_pkg::imm12_t      mem_offset;
  id_pkg::pc_t         pc_out;
  logic                redirect;
  id_pkg::pc_t         redirect_pc;

  `include "tb_id_ref.svh"

  exp_t exp_q[$];
  exp_t cur;
  int   checks;
  int   errors;

  id_stage_top dut0 (
    .clk (clk), .arst_n_i (arst_n), .inst_valid_i (inst_valid), .inst_i (inst), .pc_i (pc),
    .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
    .ex_rd_ena_i (ex_rd_ena), .ex_rd_addr_i (ex_rd_addr), .ex_rd_data_i (ex_rd_data),
    .mem_rd_ena_i (mem_rd_ena), .mem_rd_addr_i (mem_rd_addr), .mem_rd_data_i (mem_rd_data),
    .wb_rd_ena_i (wb_rd_ena), .wb_rd_addr_i (wb_rd_addr), .stall_i (stall),
    .valid_o (valid), .class_o (cls), .alu_op_o (alu_op), .funct3_o (funct3),
    .op1_o (op1), .op2_o (op2), .rd_w_ena_o (rd_w_ena), .rd_w_addr_o (rd_w_addr),
    .mem_offset_o (mem_offset), .pc_o (pc_out), .redirect_o (redirect),
    .redirect_pc_o (redirect_pc)
  );

  // register file answers in the same cycle
  assign rs1_data = rf_value(rs1_addr);
  assign rs2_data = rf_value(rs2_addr);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0s got 0x%h expected 0x%h", name, got, want);
    end
  endtask

  task automatic check_class(input string name, input id_pkg::inst_class_e got,
                             input id_pkg::inst_class_e want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_alu(input string name, input id_pkg::alu_op_e got,
                           input id_pkg::alu_op_e want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_word(input string name, input id_pkg::xlen_t got,
                            input id_pkg::xlen_t want);
    compare_value(name, got, want);
  endtask

  task automatic check_addr(input string name, input id_pkg::reg_addr_t got,
                            input id_pkg::reg_addr_t want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_funct3(input string name, input id_pkg::funct3_t got,
                              input id_pkg::funct3_t want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_offset(input string name, input id_pkg::imm12_t got,
                              input id_pkg::imm12_t want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    compare_value(name, 64'(got), 64'(want));
  endtask

  task automatic check_redirect(input logic got, input id_pkg::pc_t got_pc,
                                input logic want, input id_pkg::pc_t want_pc);
    compare_value("redirect_o", 64'(got), 64'(want));
    compare_value("redirect_pc_o", got_pc, want_pc);
  endtask

  task automatic compare_outputs(input exp_t e);
    check_flag("valid_o", valid, e.valid);
    check_class("class_o", cls, e.cls);
    check_alu("alu_op_o", alu_op, e.alu);
    check_funct3("funct3_o", funct3, e.funct3);
    check_word("op1_o", op1, e.op1);
    check_word("op2_o", op2, e.op2);
    check_flag("rd_w_ena_o", rd_w_ena, e.rd_w_ena);
    check_addr("rd_w_addr_o", rd_w_addr, e.rd_w_addr);
    check_offset("mem_offset_o", mem_offset, e.mem_offset);
    check_word("pc_o", pc_out, e.pc);
    check_redirect(redirect, redirect_pc, e.redirect, e.redirect_pc);
  endtask

  // pops one entry per capturing edge, holds it while stalled
  initial begin : compare_proc
    cur = '0;
    forever begin
      @(posedge clk);
      if (!stall && (exp_q.size() != 0)) cur = exp_q.pop_front();
      @(negedge clk);
      compare_outputs(cur);
    end
  end

  task automatic set_fwd(input logic ee, input id_pkg::reg_addr_t ea, input id_pkg::xlen_t ed,
                         input logic me, input id_pkg::reg_addr_t ma, input id_pkg::xlen_t md,
                         input logic we, input id_pkg::reg_addr_t wa);
    ex_rd_ena = ee;
    ex_rd_addr = ea;
    ex_rd_data = ed;
    mem_rd_ena = me;
    mem_rd_addr = ma;
    mem_rd_data = md;
    wb_rd_ena = we;
    wb_rd_addr = wa;
  endtask

  task automatic random_fwd();
    logic [31:0] r;
    r = rand_bits(18);
    set_fwd(r[17], r[16:12], {rand_bits(32), rand_bits(32)},
            r[11], r[10:6], {rand_bits(32), rand_bits(32)}, r[5], r[4:0]);
  endtask

  function automatic id_pkg::inst_t make_inst(input logic [6:0] opc);
    logic [31:0] r;
    r = rand_bits(25);
    return {r[24:0], opc};
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [2:0] s);
    case (s)
      3'd0:    return 7'h33;
      3'd1:    return 7'h13;
      3'd2:    return 7'h37;
      3'd3:    return 7'h17;
      3'd4:    return 7'h03;
      3'd5:    return 7'h23;
      3'd6:    return 7'h63;
      default: return 7'h33;
    endcase
  endfunction

  // called 1 ns after a rising edge, returns at the same point of the next cycle
  task automatic drive(input logic v, input id_pkg::inst_t i, input logic st);
    exp_t e;
    if (v && !st) pc = pc + 64'd4;
    inst_valid = v;
    inst = i;
    stall = st;
    e = ref_decode(v, i, pc);
    if (!st) exp_q.push_back(e);
    #1;
    check_addr("rs1_addr_o", rs1_addr, e.rs1_addr);
    check_addr("rs2_addr_o", rs2_addr, e.rs2_addr);
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int err0);
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < 10)) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: expected results were never consumed in test %0s", name);
      exp_q.delete();
    end
    @(negedge clk);
    #1;
    $display("test %0s finished with %0d errors", name, errors - err0);
    @(posedge clk);
    #1;
  endtask

  initial begin : main_seq
    logic [31:0]   r;
    id_pkg::inst_t i;
    id_pkg::xlen_t da;
    id_pkg::xlen_t db;
    int            err0;
    lfsr_state = 32'h0f29_8798;
    checks = 0;
    errors = 0;
    arst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    stall = 1'b0;
    set_fwd(1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 1'b0, 5'd0);
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err0 = errors;
    drive(1'b0, '0, 1'b0);
    drive(1'b0, '0, 1'b0);
    end_test("reset values", err0);

    err0 = errors;
    for (int k = 0; k < 60; k++) begin
      r = rand_bits(3);
      i = make_inst(pick_opcode(r[2:0]));
      if (k % 8 == 0) i[11:7] = 5'd0;
      random_fwd();
      drive(1'b1, i, 1'b0);
    end
    end_test("random instructions", err0);

    err0 = errors;
    for (int k = 0; k < 20; k++) begin
      i = make_inst(7'h33);
      da = {rand_bits(32), rand_bits(32)};
      db = {rand_bits(32), rand_bits(32)};
      case (k % 4)
        0: set_fwd(1'b1, i[19:15], da, 1'b1, i[19:15], db, 1'b0, 5'd0);
        1: set_fwd(1'b1, i[24:20], da, 1'b1, i[24:20], db, 1'b0, 5'd0);
        2: set_fwd(1'b0, i[19:15], da, 1'b1, i[19:15], db, 1'b0, 5'd0);
        default: set_fwd(1'b0, i[19:15], da, 1'b0, i[24:20], db, 1'b0, 5'd0);
      endcase
      drive(1'b1, i, 1'b0);
    end
    end_test("forwarding priority", err0);

    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      random_fwd();
      drive(1'b1, make_inst(7'h6f), 1'b0);
    end
    for (int k = 0; k < 12; k++) begin
      i = make_inst(7'h67);
      da = {rand_bits(32), rand_bits(32)};
      case (k % 4)
        0: set_fwd(1'b1, i[19:15], da, 1'b0, 5'd0, da, 1'b0, 5'd0);
        1: set_fwd(1'b0, 5'd0, da, 1'b1, i[19:15], da, 1'b0, 5'd0);
        2: set_fwd(1'b0, 5'd0, da, 1'b0, 5'd0, da, 1'b1, i[19:15]);
        default: set_fwd(1'b0, i[19:15], da, 1'b0, i[19:15], da, 1'b0, i[19:15]);
      endcase
      drive(1'b1, i, 1'b0);
    end
    end_test("jal and jalr", err0);

    err0 = errors;
    random_fwd();
    drive(1'b1, make_inst(7'h33), 1'b0);
    for (int k = 0; k < 4; k++) begin
      r = rand_bits(3);
      drive(1'b1, make_inst(pick_opcode(r[2:0])), 1'b1);
    end
    drive(1'b1, make_inst(7'h13), 1'b0);
    end_test("stall", err0);

    err0 = errors;
    random_fwd();
    drive(1'b0, make_inst(7'h33), 1'b0);
    drive(1'b1, make_inst(7'h0b), 1'b0);
    drive(1'b1, make_inst(7'h32), 1'b0);
    drive(1'b1, make_inst(7'h7f), 1'b0);
    end_test("invalid and unknown", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
